/* verilog/soc_periph_pkg.sv */
// Shared definitions for the SoC peripheral subsystem.
// Holds the APB and event widths, the address map on paddr[13:12],
// the register word offsets on paddr[4:2] and the event numbering
// used toward the fabric controller. Compile it before the RTL.
package soc_periph_pkg;

    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  evt_id_t;
    typedef logic [31:0] boot_addr_t;
    typedef logic [7:0]  jtag_reg_t;

    localparam int PER_EVT_NUM = 8;
    typedef logic [PER_EVT_NUM-1:0] per_evt_t;

    ////////////////////////////////////////
    // address map and register offsets
    ////////////////////////////////////////
    localparam logic [1:0] GPIO_REGION     = 2'd0;
    localparam logic [1:0] SOC_CTRL_REGION = 2'd1;
    localparam logic [1:0] EVT_GEN_REGION  = 2'd2; // region 3 unmapped

    localparam logic [2:0] GPIO_OUT_OFS   = 3'd0;
    localparam logic [2:0] GPIO_DIR_OFS   = 3'd1;
    localparam logic [2:0] GPIO_IN_OFS    = 3'd2;
    localparam logic [2:0] GPIO_INTEN_OFS = 3'd3;

    localparam logic [2:0] CTRL_BOOT_OFS  = 3'd0;
    localparam logic [2:0] CTRL_FETCH_OFS = 3'd1;
    localparam logic [2:0] CTRL_JTAG_OFS  = 3'd2;

    localparam logic [2:0] EVT_MASK_OFS   = 3'd0;
    localparam logic [2:0] EVT_SW_OFS     = 3'd1;
    localparam logic [2:0] EVT_STATUS_OFS = 3'd2;

    localparam boot_addr_t BOOT_ADDR_RST = 32'h1C008080;

    ////////////////////////////////////////
    // event numbering
    ////////////////////////////////////////
    localparam int EVT_LINE_GPIO     = 0;
    localparam int EVT_LINE_REF_RISE = 1;
    localparam int EVT_LINE_REF_FALL = 2; // lines 3..7 are ext inputs 0..4
    localparam evt_id_t PER_EVT_BASE = 8'd8; // sw events use ids 0..7

endpackage

/* verilog/apb_periph_decode.sv */
// APB slave front end of the peripheral subsystem.
// Splits paddr into region and word offset, raises one select per
// target and a shared write strobe in the access cycle. Read data
// from the targets is muxed back by region. Region 3 answers with
// pslverr and zero data. Purely combinational with pready tied high.
module apb_periph_decode import soc_periph_pkg::*; (
    input  apb_addr_t  paddr_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_data_t  pwdata_i,
    input  apb_data_t  gpio_rdata_i,
    input  apb_data_t  ctrl_rdata_i,
    input  apb_data_t  evt_rdata_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       gpio_sel_o,
    output logic       ctrl_sel_o,
    output logic       evt_sel_o,
    output logic       wr_en_o,
    output logic       rd_en_o,
    output logic [2:0] reg_ofs_o,
    output apb_data_t  wdata_o
);

    logic [1:0] region;
    logic       access;

    assign region    = paddr_i[13:12];
    assign reg_ofs_o = paddr_i[4:2];    // one word per register
    assign wdata_o   = pwdata_i;
    assign access    = psel_i & penable_i;

    assign wr_en_o  = access & pwrite_i;   // commits at end of access
    assign rd_en_o  = access & ~pwrite_i;
    assign pready_o = 1'b1;                // no wait states

    always_comb begin
        gpio_sel_o = 1'b0;
        ctrl_sel_o = 1'b0;
        evt_sel_o  = 1'b0;
        pslverr_o  = 1'b0;
        prdata_o   = '0;
        case (region)
            GPIO_REGION: begin
                gpio_sel_o = psel_i;
                prdata_o   = gpio_rdata_i;
            end
            SOC_CTRL_REGION: begin
                ctrl_sel_o = psel_i;
                prdata_o   = ctrl_rdata_i;
            end
            EVT_GEN_REGION: begin
                evt_sel_o = psel_i;
                prdata_o  = evt_rdata_i;
            end
            default: pslverr_o = psel_i; // unmapped so no target selected
        endcase
    end

endmodule

/* verilog/apb_gpio.sv */
// GPIO register target.
// Output, direction and interrupt enable registers written through
// the shared decoder strobe. Pins pass a two-flop synchronizer and
// GPIO_IN reads the synchronized value. A rise on any enabled pin
// gives a one-cycle interrupt pulse toward the event generator.
module apb_gpio import soc_periph_pkg::*; #(
    parameter int GPIO_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  sel_i,
    input  logic                  wr_en_i,
    input  logic [2:0]            reg_ofs_i,
    input  apb_data_t             wdata_i,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output apb_data_t             rdata_o,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_dir_o,
    output logic                  gpio_irq_o
);

    logic [GPIO_WIDTH-1:0] inten;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    logic [GPIO_WIDTH-1:0] in_sync_q;   // previous synced value
    logic                  pin_rise;

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_out_o <= '0;
            gpio_dir_o <= '0;      // all pins inputs
            inten      <= '0;
        end else if (sel_i && wr_en_i) begin
            case (reg_ofs_i)
                GPIO_OUT_OFS:   gpio_out_o <= wdata_i[GPIO_WIDTH-1:0];
                GPIO_DIR_OFS:   gpio_dir_o <= wdata_i[GPIO_WIDTH-1:0];
                GPIO_INTEN_OFS: inten      <= wdata_i[GPIO_WIDTH-1:0];
                default: ;         // GPIO_IN is read only
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_ofs_i)
            GPIO_OUT_OFS:   rdata_o[GPIO_WIDTH-1:0] = gpio_out_o;
            GPIO_DIR_OFS:   rdata_o[GPIO_WIDTH-1:0] = gpio_dir_o;
            GPIO_IN_OFS:    rdata_o[GPIO_WIDTH-1:0] = in_sync;
            GPIO_INTEN_OFS: rdata_o[GPIO_WIDTH-1:0] = inten;
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // input sync and interrupt
    ////////////////////////////////////////
    assign pin_rise = |(in_sync & ~in_sync_q & inten);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_meta    <= '0;
            in_sync    <= '0;
            in_sync_q  <= '0;
            gpio_irq_o <= 1'b0;
        end else begin
            in_meta    <= gpio_in_i;
            in_sync    <= in_meta;
            in_sync_q  <= in_sync;
            gpio_irq_o <= pin_rise;   // pulse one cycle after the rise
        end
    end

endmodule

/* verilog/apb_soc_ctrl.sv */
// SoC control register target.
// Holds the fabric controller boot address and fetch enable, and the
// JTAG exchange register. A CTRL_JTAG read returns the debugger side
// value in bits 15:8 and the value written by software in bits 7:0.
module apb_soc_ctrl import soc_periph_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       sel_i,
    input  logic       wr_en_i,
    input  logic [2:0] reg_ofs_i,
    input  apb_data_t  wdata_i,
    input  jtag_reg_t  jtag_reg_i,
    output apb_data_t  rdata_o,
    output boot_addr_t fc_bootaddr_o,
    output logic       fc_fetchen_o,
    output jtag_reg_t  jtag_reg_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fc_bootaddr_o <= BOOT_ADDR_RST;
            fc_fetchen_o  <= 1'b0;          // core held until enabled
            jtag_reg_o    <= '0;
        end else if (sel_i && wr_en_i) begin
            case (reg_ofs_i)
                CTRL_BOOT_OFS:  fc_bootaddr_o <= wdata_i;
                CTRL_FETCH_OFS: fc_fetchen_o  <= wdata_i[0];
                CTRL_JTAG_OFS:  jtag_reg_o    <= wdata_i[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_ofs_i)
            CTRL_BOOT_OFS:  rdata_o = fc_bootaddr_o;
            CTRL_FETCH_OFS: rdata_o[0] = fc_fetchen_o;
            CTRL_JTAG_OFS: begin
                rdata_o[15:8] = jtag_reg_i;   // from debugger
                rdata_o[7:0]  = jtag_reg_o;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/evt_gen_regs.sv */
// Register block of the event generator.
// EVT_MASK enables peripheral lines, a write to EVT_SW issues a
// one-cycle software event with the low 3 bits as id. EVT_STATUS
// shows the sticky drop flag in bit 0 and the FIFO level in bits 7:4.
// Reading EVT_STATUS clears the drop flag.
module evt_gen_regs import soc_periph_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       sel_i,
    input  logic       wr_en_i,
    input  logic       rd_en_i,
    input  logic [2:0] reg_ofs_i,
    input  apb_data_t  wdata_i,
    input  logic       sw_evt_drop_i,
    input  logic [3:0] fifo_level_i,
    output apb_data_t  rdata_o,
    output per_evt_t   evt_mask_o,
    output logic       sw_evt_valid_o,
    output evt_id_t    sw_evt_id_o
);

    logic err_flag;
    logic status_rd;

    assign status_rd = sel_i & rd_en_i & (reg_ofs_i == EVT_STATUS_OFS);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            evt_mask_o     <= '1;      // all lines enabled
            sw_evt_valid_o <= 1'b0;
            sw_evt_id_o    <= '0;
            err_flag       <= 1'b0;
        end else begin
            sw_evt_valid_o <= 1'b0;
            if (sel_i && wr_en_i) begin
                case (reg_ofs_i)
                    EVT_MASK_OFS: evt_mask_o <= wdata_i[PER_EVT_NUM-1:0];
                    EVT_SW_OFS: begin
                        sw_evt_valid_o <= 1'b1;
                        sw_evt_id_o    <= evt_id_t'(wdata_i[2:0]);
                    end
                    default: ;
                endcase
            end
            if (sw_evt_drop_i)
                err_flag <= 1'b1;      // a new drop wins over the clear
            else if (status_rd)
                err_flag <= 1'b0;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_ofs_i)
            EVT_MASK_OFS: rdata_o[PER_EVT_NUM-1:0] = evt_mask_o;
            EVT_SW_OFS:   rdata_o[7:0] = sw_evt_id_o;   // last sw id
            EVT_STATUS_OFS: begin
                rdata_o[0]   = err_flag;
                rdata_o[7:4] = fifo_level_i;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/evt_dispatch.sv */
// Event dispatcher toward the fabric controller.
// Detects the edges of the slow reference clock, latches rising event
// lines as pending bits and pushes at most one event per cycle into a
// small FIFO. Software strobes go first and are dropped when the FIFO
// is full; otherwise the lowest enabled pending line is taken. The
// FIFO head is offered on a valid/ready port.
module evt_dispatch import soc_periph_pkg::*; #(
    parameter int EVT_FIFO_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       slow_clk_i,
    input  logic       gpio_irq_i,
    input  logic [4:0] ext_evt_i,
    input  per_evt_t   evt_mask_i,
    input  logic       sw_evt_valid_i,
    input  evt_id_t    sw_evt_id_i,
    input  logic       fc_event_ready_i,
    output logic       sw_evt_drop_o,
    output logic [3:0] fifo_level_o,
    output logic       fc_event_valid_o,
    output evt_id_t    fc_event_data_o
);

    localparam int PTR_W = (EVT_FIFO_DEPTH > 1) ? $clog2(EVT_FIFO_DEPTH) : 1;

    logic [2:0]       slow_sync;   // two sync flops plus history
    per_evt_t         lines;
    per_evt_t         lines_q;
    per_evt_t         pending;
    per_evt_t         pend_clr;
    per_evt_t         enabled;
    logic             pick_vld;
    logic [2:0]       pick_idx;
    logic             full;
    logic             push;
    logic             pop;
    evt_id_t          push_data;
    evt_id_t          fifo_mem [EVT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    ////////////////////////////////////////
    // event lines and pending latch
    ////////////////////////////////////////
    assign lines[EVT_LINE_GPIO]     = gpio_irq_i;
    assign lines[EVT_LINE_REF_RISE] = slow_sync[1] & ~slow_sync[2];
    assign lines[EVT_LINE_REF_FALL] = ~slow_sync[1] & slow_sync[2];
    assign lines[PER_EVT_NUM-1:EVT_LINE_REF_FALL+1] = ext_evt_i;

    assign enabled = pending & evt_mask_i;   // masked bits stay pending

    always_comb begin
        pick_vld = 1'b0;
        pick_idx = '0;
        for (int i = PER_EVT_NUM - 1; i >= 0; i--) begin
            if (enabled[i]) begin
                pick_vld = 1'b1;
                pick_idx = 3'(i);          // lowest line wins
            end
        end
    end

    ////////////////////////////////////////
    // push select
    ////////////////////////////////////////
    assign full          = (fifo_level_o == 4'(EVT_FIFO_DEPTH));
    assign sw_evt_drop_o = sw_evt_valid_i & full;
    assign push          = ~full & (sw_evt_valid_i | pick_vld);
    assign push_data     = sw_evt_valid_i ? sw_evt_id_i
                                          : PER_EVT_BASE + evt_id_t'(pick_idx);
    assign pend_clr      = (push && !sw_evt_valid_i) ? per_evt_t'(1) << pick_idx : '0;

    assign pop              = fc_event_valid_o & fc_event_ready_i;
    assign fc_event_valid_o = (fifo_level_o != '0);
    assign fc_event_data_o  = fifo_mem[rd_ptr];   // head held until taken

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slow_sync    <= '0;
            lines_q      <= '0;
            pending      <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_level_o <= '0;
        end else begin
            slow_sync <= {slow_sync[1:0], slow_clk_i};
            lines_q   <= lines;
            pending   <= (pending & ~pend_clr) | (lines & ~lines_q); // repeats merge
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(EVT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(EVT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fifo_level_o <= fifo_level_o + 4'(push) - 4'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push)
            fifo_mem[wr_ptr] <= push_data;
    end

endmodule

/* verilog/soc_periph.sv */
// Top level of the SoC peripheral subsystem.
// One APB slave port reaches the GPIO, SoC control and event
// generator targets through the decoder. Peripheral and software
// events leave on the fabric controller valid/ready port.
module soc_periph import soc_periph_pkg::*; #(
    parameter int GPIO_WIDTH     = 32,
    parameter int EVT_FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  slow_clk_i,
    input  apb_addr_t             paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_data_t             pwdata_i,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    input  logic [4:0]            ext_evt_i,
    input  jtag_reg_t             jtag_reg_i,
    input  logic                  fc_event_ready_i,
    output apb_data_t             prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_dir_o,
    output boot_addr_t            fc_bootaddr_o,
    output logic                  fc_fetchen_o,
    output jtag_reg_t             jtag_reg_o,
    output logic                  fc_event_valid_o,
    output evt_id_t               fc_event_data_o
);

    logic       gpio_sel, ctrl_sel, evt_sel;
    logic       wr_en, rd_en;
    logic [2:0] reg_ofs;
    apb_data_t  wdata;
    apb_data_t  gpio_rdata, ctrl_rdata, evt_rdata;
    logic       gpio_irq;
    per_evt_t   evt_mask;
    logic       sw_evt_valid;
    evt_id_t    sw_evt_id;
    logic       sw_evt_drop;
    logic [3:0] fifo_level;

    ////////////////////////////////////////
    // APB decode and register targets
    ////////////////////////////////////////
    apb_periph_decode i_apb_periph_decode (
        .paddr_i      ( paddr_i    ), .psel_i       ( psel_i     ),
        .penable_i    ( penable_i  ), .pwrite_i     ( pwrite_i   ),
        .pwdata_i     ( pwdata_i   ), .gpio_rdata_i ( gpio_rdata ),
        .ctrl_rdata_i ( ctrl_rdata ), .evt_rdata_i  ( evt_rdata  ),
        .prdata_o     ( prdata_o   ), .pready_o     ( pready_o   ),
        .pslverr_o    ( pslverr_o  ), .gpio_sel_o   ( gpio_sel   ),
        .ctrl_sel_o   ( ctrl_sel   ), .evt_sel_o    ( evt_sel    ),
        .wr_en_o      ( wr_en      ), .rd_en_o      ( rd_en      ),
        .reg_ofs_o    ( reg_ofs    ), .wdata_o      ( wdata      )
    );

    apb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) i_apb_gpio (
        .clk_i      ( clk_i      ), .arst_n_i   ( arst_n_i   ),
        .sel_i      ( gpio_sel   ), .wr_en_i    ( wr_en      ),
        .reg_ofs_i  ( reg_ofs    ), .wdata_i    ( wdata      ),
        .gpio_in_i  ( gpio_in_i  ), .rdata_o    ( gpio_rdata ),
        .gpio_out_o ( gpio_out_o ), .gpio_dir_o ( gpio_dir_o ),
        .gpio_irq_o ( gpio_irq   )
    );

    apb_soc_ctrl i_apb_soc_ctrl (
        .clk_i         ( clk_i         ), .arst_n_i     ( arst_n_i     ),
        .sel_i         ( ctrl_sel      ), .wr_en_i      ( wr_en        ),
        .reg_ofs_i     ( reg_ofs       ), .wdata_i      ( wdata        ),
        .jtag_reg_i    ( jtag_reg_i    ), .rdata_o      ( ctrl_rdata   ),
        .fc_bootaddr_o ( fc_bootaddr_o ), .fc_fetchen_o ( fc_fetchen_o ),
        .jtag_reg_o    ( jtag_reg_o    )
    );

    ////////////////////////////////////////
    // event generator
    ////////////////////////////////////////
    evt_gen_regs i_evt_gen_regs (
        .clk_i          ( clk_i        ), .arst_n_i      ( arst_n_i    ),
        .sel_i          ( evt_sel      ), .wr_en_i       ( wr_en       ),
        .rd_en_i        ( rd_en        ), .reg_ofs_i     ( reg_ofs     ),
        .wdata_i        ( wdata        ), .sw_evt_drop_i ( sw_evt_drop ),
        .fifo_level_i   ( fifo_level   ), .rdata_o       ( evt_rdata   ),
        .evt_mask_o     ( evt_mask     ), .sw_evt_id_o   ( sw_evt_id   ),
        .sw_evt_valid_o ( sw_evt_valid )
    );

    evt_dispatch #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) i_evt_dispatch (
        .clk_i            ( clk_i            ), .arst_n_i       ( arst_n_i     ),
        .slow_clk_i       ( slow_clk_i       ), .gpio_irq_i     ( gpio_irq     ),
        .ext_evt_i        ( ext_evt_i        ), .evt_mask_i     ( evt_mask     ),
        .sw_evt_valid_i   ( sw_evt_valid     ), .sw_evt_id_i    ( sw_evt_id    ),
        .fc_event_ready_i ( fc_event_ready_i ), .sw_evt_drop_o  ( sw_evt_drop  ),
        .fifo_level_o     ( fifo_level       ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  )
    );

endmodule

/* sim/tb_soc_periph.sv */
// Testbench for the SoC peripheral subsystem.
// A table of steps (APB accesses, pin changes, output and event checks,
// ready changes and waits) is applied in order, one line per step.
// A monitor queues the event ids taken on the fabric controller port.
module tb_soc_periph import soc_periph_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         GPIO_WIDTH      = 32;
    localparam int         EVT_FIFO_DEPTH  = 4;
    localparam logic [1:0] UNMAPPED_REGION = 2'd3;
    localparam jtag_reg_t  JTAG_IN         = 8'hA5;          // debugger side value
    localparam apb_data_t  MASK_QUIET      = 32'h0000_00F9;  // ref clock lines off

    typedef enum logic [2:0] {K_WR, K_RD, K_PIN, K_OUT, K_EVT, K_QUIET, K_RDY, K_WAIT} kind_e;
    typedef struct packed {
        kind_e     kind;
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t exp;
    } step_t;

    logic                  clk_i      = 1'b0;
    logic                  slow_clk_i = 1'b0;
    logic                  arst_n_i;
    apb_addr_t             paddr_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    apb_data_t             pwdata_i;
    logic [GPIO_WIDTH-1:0] gpio_in_i;
    logic [4:0]            ext_evt_i;
    jtag_reg_t             jtag_reg_i;
    logic                  fc_event_ready_i;
    apb_data_t             prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic [GPIO_WIDTH-1:0] gpio_out_o;
    logic [GPIO_WIDTH-1:0] gpio_dir_o;
    boot_addr_t            fc_bootaddr_o;
    logic                  fc_fetchen_o;
    jtag_reg_t             jtag_reg_o;
    logic                  fc_event_valid_o;
    evt_id_t               fc_event_data_o;

    step_t       steps [$];
    evt_id_t     evt_q [$];                 // ids taken by the fabric controller
    logic [15:0] lfsr_state = 16'd80;
    int          slow_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    soc_periph #(.GPIO_WIDTH(GPIO_WIDTH), .EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) i_soc_periph (.*);

    ////////////////////////////////////////
    // clocks, monitor and timeout
    ////////////////////////////////////////
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (slow_cnt == 7) begin         // 8 system cycles per half period
            slow_cnt   <= 0;
            slow_clk_i <= ~slow_clk_i;
        end else begin
            slow_cnt <= slow_cnt + 1;
        end
    end

    always @(posedge clk_i) begin
        if (arst_n_i === 1'b1 && fc_event_valid_o && fc_event_ready_i)
            evt_q.push_back(fc_event_data_o);
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the table did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic apb_data_t rand_bits(input int n);
        apb_data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic apb_addr_t reg_addr(input logic [1:0] region, input logic [2:0] ofs);
        return {18'h0, region, 7'h0, ofs, 2'b00};
    endfunction

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_evt(input string name, input evt_id_t got, input evt_id_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bool(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s = %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk_i);                // setup cycle
        paddr_i   <= addr;
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);                // access cycle
        penable_i <= 1'b1;
        @(negedge clk_i);
        while (pready_o !== 1'b1)
            @(negedge clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);                // end of access
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic add_step(input kind_e kind, input apb_addr_t addr, input apb_data_t data,
                            input apb_data_t exp);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    task automatic run_step(input step_t s);
        apb_data_t rd;
        logic      err;
        case (s.kind)
            K_WR, K_RD: begin
                apb_xfer(s.addr, s.kind == K_WR, s.data, rd, err);
                check_bool("pslverr_o", err, s.addr[13:12] == UNMAPPED_REGION);
                if (s.kind == K_RD)
                    check_data("prdata_o", rd, s.exp);
            end
            K_PIN: begin                 // addr 0 drives gpio pins and addr 1 ext events
                @(posedge clk_i);
                if (s.addr == 0)
                    gpio_in_i <= s.data[GPIO_WIDTH-1:0];
                else
                    ext_evt_i <= s.data[4:0];
            end
            K_OUT: begin
                @(posedge clk_i);
                case (s.addr)
                    0: check_data("gpio_out_o", gpio_out_o, s.exp);
                    1: check_data("gpio_dir_o", gpio_dir_o, s.exp);
                    2: check_data("fc_bootaddr_o", fc_bootaddr_o, s.exp);
                    3: check_data("fc_fetchen_o", apb_data_t'(fc_fetchen_o), s.exp);
                    4: check_data("jtag_reg_o", apb_data_t'(jtag_reg_o), s.exp);
                    default: check_bool("fc_event_valid_o", fc_event_valid_o, s.exp[0]);
                endcase
            end
            K_EVT: begin
                while (evt_q.size() == 0)
                    @(posedge clk_i);
                check_evt("fc_event_data_o", evt_q.pop_front(), evt_id_t'(s.exp));
            end
            K_QUIET: begin
                repeat (s.data) @(posedge clk_i);
                @(negedge clk_i);
                if (evt_q.size() != 0) begin
                    $display("unexpected event id %0d taken on the fabric controller port",
                             evt_q[0]);
                    err_cnt++;
                end
            end
            K_RDY: begin
                @(posedge clk_i);
                fc_event_ready_i <= s.data[0];
            end
            default: begin               // wait step where addr 1 drops stray events
                repeat (s.data) @(posedge clk_i);
                @(negedge clk_i);
                if (s.addr[0])
                    evt_q.delete();
            end
        endcase
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////
    task automatic build_table();
        apb_addr_t reg_a [5];
        apb_data_t reg_v [5];
        apb_data_t sw_v [5];
        reg_a = '{reg_addr(GPIO_REGION, GPIO_OUT_OFS), reg_addr(GPIO_REGION, GPIO_DIR_OFS),
                  reg_addr(SOC_CTRL_REGION, CTRL_BOOT_OFS),
                  reg_addr(SOC_CTRL_REGION, CTRL_FETCH_OFS),
                  reg_addr(SOC_CTRL_REGION, CTRL_JTAG_OFS)};
        reg_v = '{rand_bits(32), rand_bits(32), 32'h1C01_0000, 32'h1, 32'h3C};
        for (int i = 0; i < 5; i++)
            sw_v[i] = rand_bits(32);     // id in the low 3 bits
        // reset values and then the ref clock lines masked off
        add_step(K_RD, reg_a[0], 0, '0);
        add_step(K_RD, reg_a[1], 0, '0);
        add_step(K_RD, reg_a[2], 0, BOOT_ADDR_RST);
        add_step(K_RD, reg_a[3], 0, '0);
        add_step(K_RD, reg_a[4], 0, {16'h0, JTAG_IN, 8'h00});
        add_step(K_RD, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), 0, 32'hFF);
        add_step(K_OUT, 2, 0, BOOT_ADDR_RST);
        add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), MASK_QUIET, 0);
        add_step(K_WAIT, 1, 20, 0);
        add_step(K_RD, reg_addr(EVT_GEN_REGION, EVT_STATUS_OFS), 0, '0);
        for (int i = 0; i < 5; i++) begin
            add_step(K_WR, reg_a[i], reg_v[i], 0);
            add_step(K_RD, reg_a[i], 0, (i == 4) ? {16'h0, JTAG_IN, 8'h3C} : reg_v[i]);
            add_step(K_OUT, i, 0, reg_v[i]);
        end
        // unmapped region leaves the registers alone
        add_step(K_WR, reg_addr(UNMAPPED_REGION, 3'd0), 32'hFFFF_FFFF, 0);
        add_step(K_RD, reg_addr(UNMAPPED_REGION, 3'd0), 0, '0);
        add_step(K_RD, reg_a[0], 0, reg_v[0]);
        add_step(K_RD, reg_a[2], 0, reg_v[2]);
        add_step(K_RD, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), 0, MASK_QUIET);
        // software events with the FIFO held full
        add_step(K_RDY, 0, 0, 0);
        for (int i = 0; i < 5; i++)
            add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_SW_OFS), sw_v[i], 0);
        add_step(K_WAIT, 0, 4, 0);
        add_step(K_OUT, 5, 0, 1);        // head offered while ready is low
        add_step(K_RDY, 0, 1, 0);
        for (int i = 0; i < 4; i++)
            add_step(K_EVT, 0, 0, {29'h0, sw_v[i][2:0]});
        add_step(K_QUIET, 0, 12, 0);     // fifth id was dropped
        add_step(K_OUT, 5, 0, 0);
        add_step(K_RD, reg_addr(EVT_GEN_REGION, EVT_STATUS_OFS), 0, 32'h1);
        add_step(K_RD, reg_addr(EVT_GEN_REGION, EVT_STATUS_OFS), 0, 32'h0);
        // gpio input with the interrupt off then on
        add_step(K_PIN, 0, 1, 0);
        add_step(K_QUIET, 0, 12, 0);
        add_step(K_RD, reg_addr(GPIO_REGION, GPIO_IN_OFS), 0, 32'h1);
        add_step(K_PIN, 0, 0, 0);
        add_step(K_WAIT, 0, 4, 0);
        add_step(K_WR, reg_addr(GPIO_REGION, GPIO_INTEN_OFS), 32'h1, 0);
        add_step(K_PIN, 0, 1, 0);
        add_step(K_EVT, 0, 0, 8);
        // ref clock edges one line at a time
        for (int l = 1; l <= 2; l++) begin
            add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), MASK_QUIET | (1 << l), 0);
            add_step(K_EVT, 0, 0, 8 + l);
            add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), MASK_QUIET, 0);
            add_step(K_WAIT, 1, 12, 0);
        end
        for (int k = 0; k < 5; k++) begin
            add_step(K_PIN, 1, 1 << k, 0);
            add_step(K_EVT, 0, 0, 11 + k);
            add_step(K_PIN, 1, 0, 0);
        end
        // masked line stays pending until enabled again
        add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), MASK_QUIET & ~32'h8, 0);
        add_step(K_PIN, 1, 1, 0);
        add_step(K_QUIET, 0, 20, 0);
        add_step(K_PIN, 1, 0, 0);
        add_step(K_WR, reg_addr(EVT_GEN_REGION, EVT_MASK_OFS), MASK_QUIET, 0);
        add_step(K_EVT, 0, 0, 11);
    endtask

    initial begin
        int errs_before;
        arst_n_i         <= 1'b0;
        paddr_i          <= '0;
        psel_i           <= 1'b0;
        penable_i        <= 1'b0;
        pwrite_i         <= 1'b0;
        pwdata_i         <= '0;
        gpio_in_i        <= '0;
        ext_evt_i        <= '0;
        jtag_reg_i       <= JTAG_IN;
        fc_event_ready_i <= 1'b1;
        build_table();
        cycle_limit = 40 * steps.size() + 200;
        repeat (8) @(posedge clk_i);
        arst_n_i <= 1'b1;
        foreach (steps[i]) begin
            errs_before = err_cnt;
            run_step(steps[i]);
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("step %0d %s: ok", i, steps[i].kind.name());
            end else begin
                fail_cnt++;
                $display("step %0d %s: FAILED", i, steps[i].kind.name());
            end
        end
        $display("%0d steps passed, %0d steps failed", pass_cnt, fail_cnt);
        if (err_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* sim.f */
verilog/soc_periph_pkg.sv
verilog/apb_periph_decode.sv
verilog/apb_gpio.sv
verilog/apb_soc_ctrl.sv
verilog/evt_gen_regs.sv
verilog/evt_dispatch.sv
verilog/soc_periph.sv
sim/tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_soc_periph -f sim.f -o tb_soc_periph \
    && ./obj_dir/tb_soc_periph > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
